/* Makefile */
# Verilator build and run of the memory subsystem testbench

TB_TOP = tb_beeb_mem

.PHONY: all lint clean

# build, run, and pass only when the pass line shows up
all:
	verilator --binary --timing --assert -f files.f --top-module $(TB_TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	verilator --lint-only --timing --assert -f files.f --top-module beeb_mem_top
	verilator --lint-only --timing --assert -f files.f --top-module $(TB_TOP)

clean:
	rm -rf obj_dir

/* files.f */
+incdir+verilog
verilog/beeb_mem_pkg.sv
verilog/mem_req_if.sv
verilog/wb_mem_front.sv
verilog/rom_slot_map.sv
verilog/beeb_mem_store.sv
verilog/beeb_mem_top.sv
verification/tb_beeb_mem.sv

/* verification/tb_beeb_mem.sv */
/* self-checking testbench for the memory subsystem that loads all ROM slots, sweeps both
   model tables, exercises RAM and the loader hold, and checks the Wishbone timing */

`timescale 1ns/100ps
`default_nettype none

`include "beeb_mem_settings.svh"

module tb_beeb_mem;

	localparam int CLK_PERIOD     = 100;
	localparam int RESET_CYCLES   = 10;
	localparam int ACK_WAIT_MAX   = 8;
	localparam int SLOTS          = 14;
	localparam int WORDS_PER_SLOT = 3;
	localparam int RAM_PAIRS      = 16;
	localparam int BANK_BYTES     = 1 << `BANK_OFFSET_W;
	localparam int RAM_SPAN       = 1 << `RAM_SEL_BIT;

	// transaction budget from the loads and bus accesses of every test step
	localparam int N_LOADS   = SLOTS * WORDS_PER_SLOT + 1;
	// mapped words of both models plus one read per empty bank (12 in B, 6 in Master)
	localparam int N_SWEEP   = SLOTS * WORDS_PER_SLOT * 2 + 18;
	localparam int N_MODEL   = 3;
	localparam int N_RAM     = RAM_PAIRS * 2 + 5;
	localparam int N_ROM_WR  = 6;
	localparam int TXN_COUNT = N_LOADS + N_SWEEP + N_MODEL + N_RAM + N_ROM_WR;

	logic                    clk_sys;
	logic                    rst_n;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	beeb_mem_pkg::cpu_addr_t wb_adr;
	beeb_mem_pkg::mem_byte_t wb_dat_w;
	beeb_mem_pkg::mem_byte_t wb_dat_r;
	logic                    wb_ack;
	logic                    model_sel;
	logic                    model_latch;
	logic                    core_held;
	logic                    load_wr;
	beeb_mem_pkg::rom_addr_t load_addr;
	beeb_mem_pkg::rom_word_t load_data;

	// reference contents by byte address
	beeb_mem_pkg::mem_byte_t rom_ref [int unsigned];
	beeb_mem_pkg::mem_byte_t ram_ref [int unsigned];
	// 1 for Master, moved by the latch pulses only
	logic                    model_ref;
	// loaded word offsets per slot as even byte offsets inside the bank
	int unsigned             word_off [SLOTS][WORDS_PER_SLOT];
	int unsigned             ram_idx [RAM_PAIRS];

	beeb_mem_top UUT (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.model_sel   (model_sel),
		.model_latch (model_latch),
		.core_held   (core_held),
		.load_wr     (load_wr),
		.load_addr   (load_addr),
		.load_data   (load_data)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ======================================================================
	// error exits
	// ======================================================================

	task automatic report_error(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	// ======================================================================
	// reference model
	// ======================================================================

	// sideways slot for a bank or -1 when the bank is empty
	function automatic int expected_slot(input logic master, input int unsigned bank);
		int result;
		if (master) begin
			case (bank)
				2:       result = 4;
				3:       result = 5;
				4:       result = 6;
				// banks 9..15 hold slots 7..13
				9, 10, 11, 12, 13, 14, 15: result = int'(bank) - 2;
				default: result = -1;
			endcase
		end else begin
			case (bank)
				4:       result = 0;
				8:       result = 1;
				14:      result = 2;
				15:      result = 3;
				default: result = -1;
			endcase
		end
		return result;
	endfunction

	function automatic beeb_mem_pkg::mem_byte_t expected_byte(
		input beeb_mem_pkg::cpu_addr_t adr);
		int unsigned             idx;
		int unsigned             phys_addr;
		int                      slot;
		beeb_mem_pkg::mem_byte_t result;
		result = '0;
		if (adr[`RAM_SEL_BIT]) begin
			// past the RAM depth reads zero
			idx = 32'(adr[`RAM_SEL_BIT-1:0]);
			if (idx < `RAM_BYTES && ram_ref.exists(idx)) begin
				result = ram_ref[idx];
			end
		end else begin
			slot = expected_slot(model_ref, 32'(adr[`ROM_PHYS_W-1:`BANK_OFFSET_W]));
			if (slot >= 0) begin
				phys_addr = slot * BANK_BYTES + 32'(adr[`BANK_OFFSET_W-1:0]);
				result    = rom_ref[phys_addr];
			end
		end
		return result;
	endfunction

	function automatic beeb_mem_pkg::cpu_addr_t rom_cpu_addr(input int unsigned bank,
		input int unsigned off);
		return beeb_mem_pkg::cpu_addr_t'(bank * BANK_BYTES + off);
	endfunction

	function automatic beeb_mem_pkg::cpu_addr_t ram_cpu_addr(input int unsigned idx);
		return beeb_mem_pkg::cpu_addr_t'(RAM_SPAN + idx);
	endfunction

	// ======================================================================
	// stimulus tasks
	// ======================================================================

	// one Wishbone classic cycle with the signals held until ack
	task automatic access_bus(input logic we, input beeb_mem_pkg::cpu_addr_t adr,
		input beeb_mem_pkg::mem_byte_t wdat, output beeb_mem_pkg::mem_byte_t rdat);
		int unsigned waited;
		waited = 0;
		rdat   = '0;
		@(posedge clk_sys);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdat;
		do begin
			@(posedge clk_sys);
			waited++;
		end while (!wb_ack && waited < ACK_WAIT_MAX);
		if (!wb_ack) begin
			abort_run($sformatf("bus hung: no wb_ack within %0d cycles for address %05h",
				ACK_WAIT_MAX, adr));
		end else begin
			rdat = wb_dat_r;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end
	endtask

	task automatic read_check(input beeb_mem_pkg::cpu_addr_t adr, input string what);
		beeb_mem_pkg::mem_byte_t got;
		beeb_mem_pkg::mem_byte_t want;
		want = expected_byte(adr);
		access_bus(1'b0, adr, '0, got);
		assert (got == want) else
			report_error($sformatf("%s at %05h read %02h, expected %02h",
				what, adr, got, want));
	endtask

	task automatic write_byte(input beeb_mem_pkg::cpu_addr_t adr,
		input beeb_mem_pkg::mem_byte_t data);
		beeb_mem_pkg::mem_byte_t unused;
		int unsigned             idx;
		access_bus(1'b1, adr, data, unused);
		// only in-range RAM keeps a write
		idx = 32'(adr[`RAM_SEL_BIT-1:0]);
		if (adr[`RAM_SEL_BIT] && idx < `RAM_BYTES) begin
			ram_ref[idx] = data;
		end
	endtask

	// loader word with the low byte to the even address
	task automatic load_rom_word(input logic held, input int unsigned phys_addr,
		input beeb_mem_pkg::rom_word_t data);
		@(posedge clk_sys);
		core_held <= held;
		load_wr   <= 1'b1;
		load_addr <= beeb_mem_pkg::rom_addr_t'(phys_addr);
		load_data <= data;
		@(posedge clk_sys);
		load_wr   <= 1'b0;
		core_held <= 1'b0;
		if (held) begin
			rom_ref[phys_addr & ~32'd1] = data[7:0];
			rom_ref[phys_addr | 32'd1]  = data[15:8];
		end
	endtask

	task automatic latch_model(input logic master);
		@(posedge clk_sys);
		model_sel   <= master;
		model_latch <= 1'b1;
		@(posedge clk_sys);
		model_latch <= 1'b0;
		model_ref = master;
	endtask

	// both bytes of every loaded word in all 16 banks and one read per empty bank
	task automatic sweep_banks();
		int          slot;
		int unsigned base;
		for (int bank = 0; bank < 16; bank++) begin
			slot = expected_slot(model_ref, bank);
			if (slot >= 0) begin
				for (int w = 0; w < WORDS_PER_SLOT; w++) begin
					base = bank * BANK_BYTES + word_off[slot][w];
					read_check(beeb_mem_pkg::cpu_addr_t'(base), "ROM even byte");
					read_check(beeb_mem_pkg::cpu_addr_t'(base + 1), "ROM odd byte");
				end
			end else begin
				// word 0 is loaded in every slot so a stray mapping reads nonzero
				read_check(rom_cpu_addr(bank, $urandom % 2), "empty bank");
			end
		end
	endtask

	// ======================================================================
	// bus protocol checks
	// ======================================================================

	ack_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wb_ack |=> !wb_ack) else report_error("wb_ack longer than one cycle");

	ack_in_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb)) else report_error("wb_ack outside cyc/stb");

	// request sampled at edge N gives ack registered at N+3 and seen at N+4
	ack_on_time: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(wb_cyc && wb_stb) |-> ##4 wb_ack) else report_error("wb_ack late");

	// no ack without a request started exactly 4 samples earlier
	ack_not_early: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wb_ack |-> ($past(wb_cyc && wb_stb, 4) && !$past(wb_cyc && wb_stb, 5)))
		else report_error("wb_ack early or unrequested");

	// ======================================================================
	// test sequence
	// ======================================================================

	initial begin
		int unsigned             seed_val;
		int unsigned             off;
		int unsigned             phys_addr;
		beeb_mem_pkg::rom_word_t word;
		seed_val    = $urandom(32'h8442);
		clk_sys     = 1'b0;
		rst_n       = 1'b0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		model_sel   = 1'b0;
		model_latch = 1'b0;
		core_held   = 1'b0;
		load_wr     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		model_ref   = 1'b0;

		repeat (RESET_CYCLES) @(posedge clk_sys);
		rst_n <= 1'b1;

		// no ack on a quiet bus
		repeat (5) begin
			@(posedge clk_sys);
			assert (!wb_ack) else report_error("wb_ack high with no request");
		end

		// first word, a random one and the last word of every slot
		for (int s = 0; s < SLOTS; s++) begin
			for (int w = 0; w < WORDS_PER_SLOT; w++) begin
				if (w == 0) begin
					off = 0;
				end else if (w == WORDS_PER_SLOT - 1) begin
					off = BANK_BYTES - 2;
				end else begin
					off = ($urandom % (BANK_BYTES / 2 - 2) + 1) * 2;
				end
				word_off[s][w] = off;
				load_rom_word(1'b1, s * BANK_BYTES + off,
					beeb_mem_pkg::rom_word_t'($urandom));
			end
		end

		// model B table
		sweep_banks();

		// select alone moves nothing so bank 8 stays on slot 1
		@(posedge clk_sys);
		model_sel <= 1'b1;
		read_check(rom_cpu_addr(8, word_off[1][0]), "B slot after unlatched select");
		read_check(rom_cpu_addr(8, word_off[1][0] + 1), "B slot after unlatched select");

		// Master table with bank 8 now empty
		latch_model(1'b1);
		sweep_banks();
		@(posedge clk_sys);
		model_sel <= 1'b0;
		read_check(rom_cpu_addr(4, word_off[6][1]), "Master slot after unlatched select");

		// RAM at both ends plus random bytes
		for (int i = 0; i < RAM_PAIRS; i++) begin
			if (i == 0) begin
				ram_idx[i] = 0;
			end else if (i == 1) begin
				ram_idx[i] = `RAM_BYTES - 1;
			end else begin
				ram_idx[i] = $urandom % `RAM_BYTES;
			end
			write_byte(ram_cpu_addr(ram_idx[i]), beeb_mem_pkg::mem_byte_t'($urandom));
		end
		for (int i = 0; i < RAM_PAIRS; i++) begin
			read_check(ram_cpu_addr(ram_idx[i]), "RAM readback");
		end
		read_check(ram_cpu_addr(`RAM_BYTES), "RAM past end");
		read_check(ram_cpu_addr(`RAM_BYTES + 1), "RAM past end");
		read_check(ram_cpu_addr(RAM_SPAN - 1), "RAM past end");
		write_byte(ram_cpu_addr(`RAM_BYTES), 8'hA5);
		read_check(ram_cpu_addr(`RAM_BYTES), "RAM write past end");

		// bus writes into ROM space are dropped
		off = word_off[13][2];
		write_byte(rom_cpu_addr(15, off), ~expected_byte(rom_cpu_addr(15, off)));
		write_byte(rom_cpu_addr(15, off + 1), ~expected_byte(rom_cpu_addr(15, off + 1)));
		read_check(rom_cpu_addr(15, off), "ROM after bus write");
		read_check(rom_cpu_addr(15, off + 1), "ROM after bus write");

		// loader shut out while the core runs
		off       = word_off[6][0];
		phys_addr = 6 * BANK_BYTES + off;
		word      = ~{rom_ref[phys_addr + 1], rom_ref[phys_addr]};
		load_rom_word(1'b0, phys_addr, word);
		read_check(rom_cpu_addr(4, off), "ROM after unheld load");
		read_check(rom_cpu_addr(4, off + 1), "ROM after unheld load");

		$display("RESULT: PASS");
		$finish;
	end

	// run length bound of ten cycles per transaction plus reset
	initial begin
		#((TXN_COUNT * 10 + RESET_CYCLES) * CLK_PERIOD);
		abort_run($sformatf("timeout: run still going after %0d cycles",
			TXN_COUNT * 10 + RESET_CYCLES));
	end

endmodule

`default_nettype wire

/* verilog/beeb_mem_pkg.sv */
/* vector types and enums shared by the memory subsystem RTL and its testbench;
   referenced by scoped names only */

`default_nettype none

`include "beeb_mem_settings.svh"

package beeb_mem_pkg;

	// ==================================================================
	// vectors with a meaning
	// ==================================================================

	// CPU external address
	typedef logic [`BEEB_ADDR_W-1:0] cpu_addr_t;

	// physical ROM byte address, slot in the top bits
	typedef logic [`ROM_PHYS_W-1:0] rom_addr_t;

	// RAM byte index, the bits below the select bit
	typedef logic [`RAM_SEL_BIT-1:0] ram_addr_t;

	// one word of the ROM store, even byte in the high half
	typedef logic [15:0] rom_word_t;

	typedef logic [7:0] mem_byte_t;

	typedef logic [`SLOT_W-1:0] slot_t;

	// ==================================================================
	// enums
	// ==================================================================

	// region a request lands in
	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_ROM,
		KIND_RAM
	} mem_kind_t;

	// bus front FSM
	typedef enum logic [1:0] {
		FRONT_IDLE,
		FRONT_BUSY,
		FRONT_ACK
	} front_state_t;

endpackage

`default_nettype wire

/* verilog/beeb_mem_settings.svh */
/* widths, depths and the RAM select bit of the external memory subsystem,
   included by the package and by every module that sizes a store or decodes an address */

`ifndef BEEB_MEM_SETTINGS_SVH
`define BEEB_MEM_SETTINGS_SVH

// ======================================================================
// address widths
// ======================================================================

// CPU external address, bit 18 picks RAM
`define BEEB_ADDR_W 19

// physical ROM byte address, 14 slots of 16 KB
`define ROM_PHYS_W 18

// byte offset inside one 16 KB bank
`define BANK_OFFSET_W 14

// ROM slot number, slots 0..13 in use
`define SLOT_W 4

// ======================================================================
// store depths
// ======================================================================

// ROM store in 16-bit words (14 * 8192)
`define ROM_WORDS 114688

// byte-wide RAM, reads past the end give zero
`define RAM_BYTES 212992

`define RAM_SEL_BIT 18

`endif

/* verilog/beeb_mem_store.sv */
/* ROM and RAM arrays with the ROM loader; serves one translated request per cycle
   and returns the read byte with done one edge later */

`timescale 1ns/100ps
`default_nettype none

`include "beeb_mem_settings.svh"

module beeb_mem_store (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire                          core_held,
	input  wire                          load_wr,
	input  wire beeb_mem_pkg::rom_addr_t load_addr,
	input  wire beeb_mem_pkg::rom_word_t load_data,
	mem_req_if.store                     req
);

	// ROM word holds the even byte in 15:8, the odd one in 7:0
	beeb_mem_pkg::rom_word_t rom [`ROM_WORDS];
	beeb_mem_pkg::mem_byte_t ram [`RAM_BYTES];

	logic [`ROM_PHYS_W-2:0]  load_idx;
	logic [`ROM_PHYS_W-2:0]  rom_idx;
	beeb_mem_pkg::ram_addr_t ram_idx;

	// read side registers
	beeb_mem_pkg::rom_word_t rom_q;
	beeb_mem_pkg::mem_byte_t ram_q;
	beeb_mem_pkg::mem_kind_t kind_q;
	logic                    lsb_q;

	assign load_idx = load_addr[`ROM_PHYS_W-1:1];
	assign rom_idx  = req.phys[`ROM_PHYS_W-1:1];
	assign ram_idx  = beeb_mem_pkg::ram_addr_t'(req.phys);

	// ==================================================================
	// ROM loader
	// ==================================================================

	// image arrives as 16-bit words, bytes swapped into the store
	always_ff @(posedge clk_sys) begin
		if (load_wr && core_held && load_idx < (`ROM_PHYS_W-1)'(`ROM_WORDS)) begin
			rom[load_idx] <= {load_data[7:0], load_data[15:8]};
		end
	end

	// ==================================================================
	// request port
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (req.valid && req.kind == beeb_mem_pkg::KIND_ROM) begin
			rom_q <= rom[rom_idx];
		end
	end

	// read-first RAM, write only for an in-range RAM hit
	always_ff @(posedge clk_sys) begin
		if (req.valid && req.kind == beeb_mem_pkg::KIND_RAM) begin
			ram_q <= ram[ram_idx];
			if (req.we) begin
				ram[ram_idx] <= req.wdata;
			end
		end
	end

	// byte select info follows the data
	always_ff @(posedge clk_sys) begin
		if (req.valid) begin
			kind_q <= req.kind;
			lsb_q  <= req.phys[0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			req.done <= 1'b0;
		end else begin
			req.done <= req.valid;
		end
	end

	// byte extraction, unmapped reads give zero
	always_comb begin
		case (kind_q)
			beeb_mem_pkg::KIND_ROM: req.rdata = lsb_q ? rom_q[7:0] : rom_q[15:8];
			beeb_mem_pkg::KIND_RAM: req.rdata = ram_q;
			default:                req.rdata = '0;
		endcase
	end

	// loader is shut out while the core runs
	load_needs_hold: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(load_wr && !core_held) |=> (rom[$past(load_idx)] == $past(rom[load_idx]))
	) else $error("ROM changed by load_wr without core_held");

endmodule

`default_nettype wire

/* verilog/beeb_mem_top.sv */
/* top of the external memory subsystem: Wishbone classic slave for the CPU core,
   model select and ROM loader as plain ports */

`timescale 1ns/100ps
`default_nettype none

module beeb_mem_top (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	// Wishbone classic slave
	input  wire                          wb_cyc,
	input  wire                          wb_stb,
	input  wire                          wb_we,
	input  wire beeb_mem_pkg::cpu_addr_t wb_adr,
	input  wire beeb_mem_pkg::mem_byte_t wb_dat_w,
	output beeb_mem_pkg::mem_byte_t      wb_dat_r,
	output logic                         wb_ack,
	// model, 1 = Master
	input  wire                          model_sel,
	input  wire                          model_latch,
	// ROM loader
	input  wire                          core_held,
	input  wire                          load_wr,
	input  wire beeb_mem_pkg::rom_addr_t load_addr,
	input  wire beeb_mem_pkg::rom_word_t load_data
);

	// front to mapper, reply comes back through the mapper
	mem_req_if cpu_req ();
	// mapper to store
	mem_req_if phys_req ();

	wb_mem_front u_front (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.req      (cpu_req)
	);

	rom_slot_map u_map (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.model_sel   (model_sel),
		.model_latch (model_latch),
		.cpu         (cpu_req),
		.phys        (phys_req)
	);

	beeb_mem_store u_store (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.core_held (core_held),
		.load_wr   (load_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.req       (phys_req)
	);

endmodule

`default_nettype wire

/* verilog/mem_req_if.sv */
/* one memory request and its reply between two stages of the pipeline;
   valid and done are single-cycle pulses */

`timescale 1ns/100ps
`default_nettype none

interface mem_req_if;

	// request side
	logic                   valid;
	logic                   we;
	beeb_mem_pkg::cpu_addr_t addr;
	beeb_mem_pkg::mem_byte_t wdata;

	// filled in by the slot mapper
	beeb_mem_pkg::mem_kind_t kind;
	beeb_mem_pkg::rom_addr_t phys;

	// reply
	beeb_mem_pkg::mem_byte_t rdata;
	logic                   done;

	// bus front, raises a request and waits for the reply
	modport front (
		output valid,
		output we,
		output addr,
		output wdata,
		input  rdata,
		input  done
	);

	// mapper driving the translated request downstream
	modport mapper (
		output valid,
		output we,
		output wdata,
		output kind,
		output phys,
		input  rdata,
		input  done
	);

	// consumer of a request, returns the reply
	modport store (
		input  valid,
		input  we,
		input  addr,
		input  wdata,
		input  kind,
		input  phys,
		output rdata,
		output done
	);

endinterface

`default_nettype wire

/* verilog/rom_slot_map.sv */
/* model latch and CPU address decode into ROM slot, RAM or unmapped;
   one register stage between the bus front and the store */

`timescale 1ns/100ps
`default_nettype none

`include "beeb_mem_settings.svh"

module rom_slot_map (
	input  wire       clk_sys,
	input  wire       rst_n,
	input  wire       model_sel,
	input  wire       model_latch,
	mem_req_if.store  cpu,
	mem_req_if.mapper phys
);

	// 1 = Master 128, 0 = model B
	logic                    model_q;
	logic [`SLOT_W-1:0]      bank;
	logic                    slot_hit;
	beeb_mem_pkg::slot_t     slot;
	beeb_mem_pkg::ram_addr_t ram_idx;
	beeb_mem_pkg::mem_kind_t kind_c;
	beeb_mem_pkg::rom_addr_t phys_c;

	// model only moves on the latch pulse
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			model_q <= 1'b0;
		end else if (model_latch) begin
			model_q <= model_sel;
		end
	end

	// ==================================================================
	// sideways slot table, keyed by model and address bits 17:14
	// ==================================================================

	assign bank = cpu.addr[`ROM_PHYS_W-1:`BANK_OFFSET_W];

	always_comb begin
		slot_hit = 1'b1;
		case ({model_q, bank})
			// model B: OS, MMFS, RAM master, BASIC 2
			5'b0_0100: slot = 4'd0;
			5'b0_1000: slot = 4'd1;
			5'b0_1110: slot = 4'd2;
			5'b0_1111: slot = 4'd3;
			// Master: ADFS, MMFS, MOS, DFS, utilities, BASIC 4, terminal
			5'b1_0010: slot = 4'd4;
			5'b1_0011: slot = 4'd5;
			5'b1_0100: slot = 4'd6;
			5'b1_1001: slot = 4'd7;
			5'b1_1010: slot = 4'd8;
			5'b1_1011: slot = 4'd9;
			5'b1_1100: slot = 4'd10;
			5'b1_1101: slot = 4'd11;
			5'b1_1110: slot = 4'd12;
			5'b1_1111: slot = 4'd13;
			default: begin
				// empty bank, reads as zero
				slot     = 4'd0;
				slot_hit = 1'b0;
			end
		endcase
	end

	// region decode
	assign ram_idx = cpu.addr[`RAM_SEL_BIT-1:0];

	always_comb begin
		if (cpu.addr[`RAM_SEL_BIT]) begin
			kind_c = (ram_idx < beeb_mem_pkg::ram_addr_t'(`RAM_BYTES)) ?
				beeb_mem_pkg::KIND_RAM : beeb_mem_pkg::KIND_NONE;
			phys_c = beeb_mem_pkg::rom_addr_t'(ram_idx);
		end else begin
			kind_c = slot_hit ? beeb_mem_pkg::KIND_ROM : beeb_mem_pkg::KIND_NONE;
			// slot * 16 KB + offset
			phys_c = {slot, cpu.addr[`BANK_OFFSET_W-1:0]};
		end
	end

	// ==================================================================
	// output stage
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			phys.valid <= 1'b0;
		end else begin
			phys.valid <= cpu.valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cpu.valid) begin
			phys.kind  <= kind_c;
			phys.phys  <= phys_c;
			phys.we    <= cpu.we;
			phys.wdata <= cpu.wdata;
		end
	end

	// reply goes straight back to the front
	assign cpu.rdata = phys.rdata;
	assign cpu.done  = phys.done;

	// a translated ROM request stays inside the 14 loaded slots
	rom_slot_range: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(phys.valid && phys.kind == beeb_mem_pkg::KIND_ROM) |->
			(phys.phys[`ROM_PHYS_W-1:`BANK_OFFSET_W] <= 4'd13)
	) else $error("ROM slot above 13");

endmodule

`default_nettype wire

/* verilog/wb_mem_front.sv */
/* Wishbone classic slave in front of the memory pipeline; takes one request per
   bus cycle and returns ack with the read byte three edges after sampling */

`timescale 1ns/100ps
`default_nettype none

module wb_mem_front (
	input  wire                       clk_sys,
	input  wire                       rst_n,
	input  wire                       wb_cyc,
	input  wire                       wb_stb,
	input  wire                       wb_we,
	input  wire beeb_mem_pkg::cpu_addr_t wb_adr,
	input  wire beeb_mem_pkg::mem_byte_t wb_dat_w,
	output beeb_mem_pkg::mem_byte_t   wb_dat_r,
	output logic                      wb_ack,
	mem_req_if.front                  req
);

	beeb_mem_pkg::front_state_t state;

	// ==================================================================
	// control FSM
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state     <= beeb_mem_pkg::FRONT_IDLE;
			req.valid <= 1'b0;
			wb_ack    <= 1'b0;
		end else begin
			// valid lasts a single cycle
			req.valid <= 1'b0;
			wb_ack    <= 1'b0;
			case (state)
				beeb_mem_pkg::FRONT_IDLE: begin
					if (wb_cyc && wb_stb) begin
						req.valid <= 1'b1;
						state     <= beeb_mem_pkg::FRONT_BUSY;
					end
				end
				beeb_mem_pkg::FRONT_BUSY: begin
					// no ack if the master gave up the cycle meanwhile
					if (req.done) begin
						wb_ack <= wb_cyc && wb_stb;
						state  <= beeb_mem_pkg::FRONT_ACK;
					end
				end
				beeb_mem_pkg::FRONT_ACK: begin
					// ack drops here, next request on the following edge
					state <= beeb_mem_pkg::FRONT_IDLE;
				end
				default: begin
					state <= beeb_mem_pkg::FRONT_IDLE;
				end
			endcase
		end
	end

	// ==================================================================
	// request and reply payload
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		// master holds its signals, capture once on entry
		if (state == beeb_mem_pkg::FRONT_IDLE && wb_cyc && wb_stb) begin
			req.we    <= wb_we;
			req.addr  <= wb_adr;
			req.wdata <= wb_dat_w;
		end
		// read byte lines up with ack
		if (state == beeb_mem_pkg::FRONT_BUSY && req.done) begin
			wb_dat_r <= req.rdata;
		end
	end

	// ==================================================================
	// checks
	// ==================================================================

	// ack only inside an active bus cycle
	ack_in_cycle: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb)
	) else $error("wb_ack outside cyc/stb");

	// reply from the store only while a request is outstanding
	done_when_busy: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		req.done |-> (state == beeb_mem_pkg::FRONT_BUSY)
	) else $error("done while front not busy");

endmodule

`default_nettype wire
